// File: compile.f
hw/core_pkg.sv
hw/core_ifs.sv
hw/decode_stage.sv
hw/operand_stage.sv
hw/execute_stage.sv
hw/writeback_stage.sv
hw/riscv_core.sv
verification/core_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module core_tb -f compile.f --Mdir obj_dir -o core_sim \
    > build.log 2>&1 &&
./obj_dir/core_sim > sim.log 2>&1 ||
{ echo "build or simulation error, see build.log and sim.log"; exit 1; }
grep -q "Test failed" sim.log && { echo "simulation FAILED, see sim.log"; exit 1; } ||
{ echo "simulation passed"; exit 0; }

// File: verification/core_tb.sv
module core_tb;

    localparam logic [31:0] RESET_PC       = 32'h0000_0100;
    localparam int          PROG_LEN       = 8;
    localparam int          CASES          = 5;
    localparam int          RESET_CYCLES   = 10;
    localparam int          RUN_CYCLES     = 60;
    localparam int          TIMEOUT_CYCLES = CASES * 80;
    localparam logic [31:0] PROG_END       = RESET_PC + 32'(PROG_LEN * 4);
    // jal x0, 0 keeps fetch parked past the end
    localparam logic [31:0] JAL_SELF       = 32'h0000_006f;
    localparam logic [31:0] NOP            = 32'h0000_0013;

    logic        clk;
    logic        reset_i;
    logic        fetch_valid_i;
    logic [31:0] fetch_pc_i;
    logic [31:0] fetch_inst_i;
    logic        fetch_ready_o;
    logic        redirect_valid_o;
    logic [31:0] redirect_pc_o;
    logic [31:0] gp_o;

    logic [31:0] prog [CASES][PROG_LEN];
    logic [31:0] exp_gp [CASES];
    int          exp_redirects [CASES];

    logic [15:0] lfsr_state = 16'd3;
    logic [31:0] fetch_pc;
    int          cur_row;
    int          reset_hits;
    int          redirects;
    int          checks;
    int          errors;
    int          cycle_count;

    riscv_core #(
        .RESET_PC (RESET_PC)
    ) i_riscv_core (
        .clk              (clk),
        .reset_i          (reset_i),
        .fetch_valid_i    (fetch_valid_i),
        .fetch_pc_i       (fetch_pc_i),
        .fetch_inst_i     (fetch_inst_i),
        .fetch_ready_o    (fetch_ready_o),
        .redirect_valid_o (redirect_valid_o),
        .redirect_pc_o    (redirect_pc_o),
        .gp_o             (gp_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // instruction encoders
    ////////////////////////////////////////////////////////////////////////////
    function automatic logic [31:0] encode_r(input logic [6:0] f7, input logic [2:0] f3,
                                             input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] encode_addi(input logic [4:0] rd, input logic [4:0] rs1,
                                                input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] encode_lui(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic logic [31:0] encode_b(input logic [2:0] f3, input logic [4:0] rs1,
                                             input logic [4:0] rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] encode_jal(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic random_bit(output logic b);
        lfsr_state = lfsr_next(lfsr_state);
        b = lfsr_state[0];
    endtask

    function automatic logic [31:0] word_at(input int row, input logic [31:0] pc);
        logic [31:0] offset;
        offset = pc - RESET_PC;
        if (pc >= RESET_PC && pc < PROG_END) begin
            return prog[row][offset[4:2]];
        end
        return JAL_SELF;
    endfunction

    task automatic load_table();
        // dependent chain, x3 = ((((-3 - 0x6a) ^ 0x35) | 0x6a) & (-3 - 0x6a))
        prog[0] = '{encode_addi(5'd1, 5'd0, 12'h035), encode_addi(5'd7, 5'd0, 12'hffd),
                    encode_r(7'h00, 3'b000, 5'd2, 5'd1, 5'd1),
                    encode_r(7'h20, 3'b000, 5'd4, 5'd7, 5'd2),
                    encode_r(7'h00, 3'b100, 5'd5, 5'd4, 5'd1),
                    encode_r(7'h00, 3'b110, 5'd6, 5'd5, 5'd2),
                    encode_r(7'h00, 3'b111, 5'd3, 5'd6, 5'd4), NOP};
        exp_gp[0]        = 32'hffff_ff82;
        exp_redirects[0] = 1;
        // upper immediate plus a negative addi
        prog[1] = '{encode_lui(5'd3, 20'habcde), encode_addi(5'd3, 5'd3, 12'hedd),
                    NOP, NOP, NOP, NOP, NOP, NOP};
        exp_gp[1]        = 32'habcd_e000 - 32'h0000_0123;
        exp_redirects[1] = 1;
        // taken beq jumps over two writes of x3
        prog[2] = '{encode_addi(5'd3, 5'd0, 12'h011), encode_addi(5'd1, 5'd0, 12'h005),
                    encode_addi(5'd2, 5'd0, 12'h005), encode_b(3'b000, 5'd1, 5'd2, 13'd12),
                    encode_addi(5'd3, 5'd0, 12'h7ff), encode_r(7'h00, 3'b100, 5'd3, 5'd3, 5'd1),
                    encode_addi(5'd3, 5'd3, 12'h022), NOP};
        exp_gp[2]        = 32'h0000_0033;
        exp_redirects[2] = 2;
        // bne with equal operands falls through
        prog[3] = '{encode_addi(5'd1, 5'd0, 12'h009), encode_addi(5'd2, 5'd0, 12'h009),
                    encode_addi(5'd3, 5'd0, 12'h040), encode_b(3'b001, 5'd1, 5'd2, 13'd12),
                    encode_addi(5'd3, 5'd3, 12'h001), encode_addi(5'd3, 5'd3, 12'h002),
                    NOP, NOP};
        exp_gp[3]        = 32'h0000_0043;
        exp_redirects[3] = 1;
        // link of jal at RESET_PC+4, plus x1
        prog[4] = '{encode_addi(5'd1, 5'd0, 12'h020), encode_jal(5'd3, 21'd8),
                    encode_addi(5'd3, 5'd0, 12'h555), encode_r(7'h00, 3'b000, 5'd3, 5'd3, 5'd1),
                    NOP, NOP, NOP, NOP};
        exp_gp[4]        = RESET_PC + 32'd4 + 32'd4 + 32'h0000_0020;
        exp_redirects[4] = 2;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // fetch model, called on each falling edge
    ////////////////////////////////////////////////////////////////////////////
    task automatic fetch_step();
        logic b0;
        logic b1;
        if (redirect_valid_o) begin
            if (redirect_pc_o == RESET_PC) begin
                reset_hits++;
            end
            if (redirect_pc_o >= RESET_PC && redirect_pc_o < PROG_END) begin
                redirects++;
            end
            fetch_pc      = redirect_pc_o;
            fetch_valid_i = 1'b0;
        end else begin
            random_bit(b0);
            random_bit(b1);
            fetch_valid_i = b0 | b1;
            fetch_pc_i    = fetch_pc;
            fetch_inst_i  = word_at(cur_row, fetch_pc);
            // ready is stable until the next rising edge
            if (fetch_valid_i && fetch_ready_o) begin
                fetch_pc = fetch_pc + 32'd4;
            end
        end
    endtask

    task automatic run_row(input int row);
        cur_row    = row;
        reset_hits = 0;
        redirects  = 0;
        @(negedge clk);
        reset_i       = 1'b1;
        fetch_valid_i = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        reset_i = 1'b0;
        checks++;
        assert (fetch_ready_o === 1'b1) else begin
            errors++;
            $display("FAIL %0t: row %0d fetch_ready_o low right after reset", $time, row);
        end
        fetch_step();
        repeat (RUN_CYCLES - 1) begin
            @(negedge clk);
            fetch_step();
        end
        checks++;
        assert (reset_hits == 1) else begin
            errors++;
            $display("FAIL %0t: row %0d saw %0d redirects to reset pc, expected 1",
                     $time, row, reset_hits);
        end
        checks++;
        assert (redirects == exp_redirects[row]) else begin
            errors++;
            $display("FAIL %0t: row %0d saw %0d redirects, expected %0d",
                     $time, row, redirects, exp_redirects[row]);
        end
        checks++;
        assert (gp_o === exp_gp[row]) else begin
            errors++;
            $display("FAIL %0t: row %0d gp_o %h, expected %h", $time, row, gp_o, exp_gp[row]);
        end
    endtask

    initial begin
        reset_i       = 1'b1;
        fetch_valid_i = 1'b0;
        fetch_pc_i    = '0;
        fetch_inst_i  = NOP;
        fetch_pc      = RESET_PC;
        checks        = 0;
        errors        = 0;
        load_table();
        for (int r = 0; r < CASES; r++) begin
            run_row(r);
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
        $display("checks: %0d, errors: %0d", checks, errors);
        $display("Test failed");
        $finish;
    end

endmodule

// File: hw/riscv_core.sv
module riscv_core #(
    parameter logic [core_pkg::XLEN-1:0] RESET_PC = 32'h0000_0100
) (
    input  logic                      clk,
    input  logic                      reset_i,
    input  logic                      fetch_valid_i,
    input  logic [core_pkg::XLEN-1:0] fetch_pc_i,
    input  logic [31:0]               fetch_inst_i,
    output logic                      fetch_ready_o,
    output logic                      redirect_valid_o,
    output logic [core_pkg::XLEN-1:0] redirect_pc_o,
    output logic [core_pkg::XLEN-1:0] gp_o
);
    import core_pkg::*;

    logic                  stall;
    logic                  redirect_now;
    logic [REG_ADDR_W-1:0] rf_raddr1;
    logic [REG_ADDR_W-1:0] rf_raddr2;
    logic [XLEN-1:0]       rf_rdata1;
    logic [XLEN-1:0]       rf_rdata2;

    uop_if id_uop ();
    uop_if ds_uop ();
    fwd_if fwd_exe ();
    fwd_if fwd_wb ();
    fwd_if fwd_res ();

    decode_stage i_decode_stage (
        .clk              (clk),
        .reset_i          (reset_i),
        .fetch_valid_i    (fetch_valid_i),
        .fetch_pc_i       (fetch_pc_i),
        .fetch_inst_i     (fetch_inst_i),
        .fetch_ready_o    (fetch_ready_o),
        .stall_i          (stall),
        .redirect_now_i   (redirect_now),
        .redirect_valid_i (redirect_valid_o),
        .uop              (id_uop)
    );

    operand_stage i_operand_stage (
        .clk            (clk),
        .reset_i        (reset_i),
        .id_uop         (id_uop),
        .ds_uop         (ds_uop),
        .fwd_exe        (fwd_exe),
        .fwd_wb         (fwd_wb),
        .rf_rdata1_i    (rf_rdata1),
        .rf_rdata2_i    (rf_rdata2),
        .rf_raddr1_o    (rf_raddr1),
        .rf_raddr2_o    (rf_raddr2),
        .stall_o        (stall),
        .redirect_now_i (redirect_now)
    );

    execute_stage #(
        .RESET_PC (RESET_PC)
    ) i_execute_stage (
        .clk              (clk),
        .reset_i          (reset_i),
        .ds_uop           (ds_uop),
        .fwd_exe          (fwd_exe),
        .fwd_res          (fwd_res),
        .redirect_now_o   (redirect_now),
        .redirect_valid_o (redirect_valid_o),
        .redirect_pc_o    (redirect_pc_o)
    );

    writeback_stage i_writeback_stage (
        .clk         (clk),
        .reset_i     (reset_i),
        .fwd_res     (fwd_res),
        .fwd_wb      (fwd_wb),
        .rf_raddr1_i (rf_raddr1),
        .rf_raddr2_i (rf_raddr2),
        .rf_rdata1_o (rf_rdata1),
        .rf_rdata2_o (rf_rdata2),
        .gp_o        (gp_o)
    );

endmodule

// File: hw/writeback_stage.sv
module writeback_stage (
    input  logic                            clk,
    input  logic                            reset_i,
    fwd_if.rcv                              fwd_res,
    fwd_if.drv                              fwd_wb,
    input  logic [core_pkg::REG_ADDR_W-1:0] rf_raddr1_i,
    input  logic [core_pkg::REG_ADDR_W-1:0] rf_raddr2_i,
    output logic [core_pkg::XLEN-1:0]       rf_rdata1_o,
    output logic [core_pkg::XLEN-1:0]       rf_rdata2_o,
    output logic [core_pkg::XLEN-1:0]       gp_o
);
    import core_pkg::*;

    logic                  wb_valid;
    logic [REG_ADDR_W-1:0] wb_addr;
    logic [XLEN-1:0]       wb_data;
    logic [XLEN-1:0]       regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= fwd_res.valid && fwd_res.fwdable;
        end
    end

    always_ff @(posedge clk) begin
        wb_addr <= fwd_res.addr;
        wb_data <= fwd_res.wdata;
    end

    // x0 stays unwritten and reads as zero
    always_ff @(posedge clk) begin
        if (wb_valid && wb_addr != '0) begin
            regs[wb_addr] <= wb_data;
        end
    end

    assign rf_rdata1_o = (rf_raddr1_i == '0) ? '0 : regs[rf_raddr1_i];
    assign rf_rdata2_o = (rf_raddr2_i == '0) ? '0 : regs[rf_raddr2_i];
    assign gp_o        = regs[3];

    assign fwd_wb.valid   = wb_valid;
    assign fwd_wb.fwdable = 1'b1;
    assign fwd_wb.addr    = wb_addr;
    assign fwd_wb.wdata   = wb_data;

endmodule

// File: hw/execute_stage.sv
module execute_stage #(
    parameter logic [core_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  logic                      clk,
    input  logic                      reset_i,
    uop_if.dst                        ds_uop,
    fwd_if.drv                        fwd_exe,
    fwd_if.drv                        fwd_res,
    output logic                      redirect_now_o,
    output logic                      redirect_valid_o,
    output logic [core_pkg::XLEN-1:0] redirect_pc_o
);
    import core_pkg::*;

    logic                  ex_valid;
    logic [XLEN-1:0]       ex_pc;
    alu_op_e               ex_alu_op;
    br_kind_e              ex_br_kind;
    logic                  ex_use_imm;
    logic [XLEN-1:0]       ex_imm;
    logic [REG_ADDR_W-1:0] ex_rd;
    logic                  ex_rf_wen;
    logic                  ex_link;
    logic [XLEN-1:0]       ex_op1;
    logic [XLEN-1:0]       ex_rs2_data;
    logic [XLEN-1:0]       op2;
    logic [XLEN-1:0]       alu_out;
    logic [XLEN-1:0]       result;
    logic [XLEN-1:0]       target;
    logic                  taken;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= ds_uop.valid;
        end
    end

    always_ff @(posedge clk) begin
        ex_pc       <= ds_uop.pc;
        ex_alu_op   <= ds_uop.alu_op;
        ex_br_kind  <= ds_uop.br_kind;
        ex_use_imm  <= ds_uop.use_imm;
        ex_imm      <= ds_uop.imm;
        ex_rd       <= ds_uop.rd;
        ex_rf_wen   <= ds_uop.rf_wen;
        ex_link     <= ds_uop.link;
        ex_op1      <= ds_uop.rs1_data;
        ex_rs2_data <= ds_uop.rs2_data;
    end

    ////////////////////////////////////////////////////////////////////////////
    // alu and branch resolution
    ////////////////////////////////////////////////////////////////////////////
    assign op2 = ex_use_imm ? ex_imm : ex_rs2_data;

    always_comb begin
        case (ex_alu_op)
            ALU_SUB:   alu_out = ex_op1 - op2;
            ALU_AND:   alu_out = ex_op1 & op2;
            ALU_OR:    alu_out = ex_op1 | op2;
            ALU_XOR:   alu_out = ex_op1 ^ op2;
            ALU_PASS2: alu_out = op2;
            default:   alu_out = ex_op1 + op2;
        endcase
    end

    assign result = ex_link ? ex_pc + XLEN'(4) : alu_out;
    assign target = ex_pc + ex_imm;

    always_comb begin
        case (ex_br_kind)
            BR_EQ:   taken = ex_op1 == ex_rs2_data;
            BR_NE:   taken = ex_op1 != ex_rs2_data;
            BR_JAL:  taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    assign redirect_now_o = ex_valid && taken;

    // fetch sees the redirect one cycle later, reset starts it at RESET_PC
    always_ff @(posedge clk) begin
        if (reset_i) begin
            redirect_valid_o <= 1'b1;
            redirect_pc_o    <= RESET_PC;
        end else begin
            redirect_valid_o <= redirect_now_o;
            redirect_pc_o    <= target;
        end
    end

    // only a link value is final this early
    assign fwd_exe.valid   = ex_valid && ex_rf_wen;
    assign fwd_exe.fwdable = ex_link;
    assign fwd_exe.addr    = ex_rd;
    assign fwd_exe.wdata   = result;

    assign fwd_res.valid   = ex_valid && ex_rf_wen;
    assign fwd_res.fwdable = 1'b1;
    assign fwd_res.addr    = ex_rd;
    assign fwd_res.wdata   = result;

    // the flush empties data select, so the next entry here is never valid
    a_no_double_redirect: assert property (@(posedge clk) disable iff (reset_i)
        redirect_now_o |=> !redirect_now_o);

endmodule

// File: hw/operand_stage.sv
module operand_stage (
    input  logic                            clk,
    input  logic                            reset_i,
    uop_if.dst                              id_uop,
    uop_if.src                              ds_uop,
    fwd_if.rcv                              fwd_exe,
    fwd_if.rcv                              fwd_wb,
    input  logic [core_pkg::XLEN-1:0]       rf_rdata1_i,
    input  logic [core_pkg::XLEN-1:0]       rf_rdata2_i,
    output logic [core_pkg::REG_ADDR_W-1:0] rf_raddr1_o,
    output logic [core_pkg::REG_ADDR_W-1:0] rf_raddr2_o,
    output logic                            stall_o,
    input  logic                            redirect_now_i
);
    import core_pkg::*;

    logic                  ds_valid;
    logic [XLEN-1:0]       ds_pc;
    alu_op_e               ds_alu_op;
    br_kind_e              ds_br_kind;
    logic                  ds_use_imm;
    logic [XLEN-1:0]       ds_imm;
    logic [REG_ADDR_W-1:0] ds_rd;
    logic                  ds_rf_wen;
    logic                  ds_link;
    logic [REG_ADDR_W-1:0] ds_rs1;
    logic [REG_ADDR_W-1:0] ds_rs2;
    logic                  exe_hit1;
    logic                  exe_hit2;
    logic                  wb_hit1;
    logic                  wb_hit2;

    always_ff @(posedge clk) begin
        if (reset_i || redirect_now_i) begin
            ds_valid <= 1'b0;
        end else if (!stall_o) begin
            ds_valid <= id_uop.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_o) begin
            ds_pc      <= id_uop.pc;
            ds_alu_op  <= id_uop.alu_op;
            ds_br_kind <= id_uop.br_kind;
            ds_use_imm <= id_uop.use_imm;
            ds_imm     <= id_uop.imm;
            ds_rd      <= id_uop.rd;
            ds_rf_wen  <= id_uop.rf_wen;
            ds_link    <= id_uop.link;
            ds_rs1     <= id_uop.rs1;
            ds_rs2     <= id_uop.rs2;
        end
    end

    assign rf_raddr1_o = ds_rs1;
    assign rf_raddr2_o = ds_rs2;

    // x0 never matches
    assign exe_hit1 = fwd_exe.valid && ds_rs1 != '0 && fwd_exe.addr == ds_rs1;
    assign exe_hit2 = fwd_exe.valid && ds_rs2 != '0 && fwd_exe.addr == ds_rs2;
    assign wb_hit1  = fwd_wb.valid && ds_rs1 != '0 && fwd_wb.addr == ds_rs1;
    assign wb_hit2  = fwd_wb.valid && ds_rs2 != '0 && fwd_wb.addr == ds_rs2;

    // alu result still in flight, wait for write-back
    assign stall_o = ds_valid && !fwd_exe.fwdable && (exe_hit1 || exe_hit2);

    // a redirect also kills the entry leaving for execute
    assign ds_uop.valid    = ds_valid && !stall_o && !redirect_now_i;
    assign ds_uop.pc       = ds_pc;
    assign ds_uop.alu_op   = ds_alu_op;
    assign ds_uop.br_kind  = ds_br_kind;
    assign ds_uop.use_imm  = ds_use_imm;
    assign ds_uop.imm      = ds_imm;
    assign ds_uop.rd       = ds_rd;
    assign ds_uop.rf_wen   = ds_rf_wen;
    assign ds_uop.link     = ds_link;
    assign ds_uop.rs1      = ds_rs1;
    assign ds_uop.rs2      = ds_rs2;
    assign ds_uop.rs1_data = exe_hit1 ? fwd_exe.wdata : wb_hit1 ? fwd_wb.wdata : rf_rdata1_i;
    assign ds_uop.rs2_data = exe_hit2 ? fwd_exe.wdata : wb_hit2 ? fwd_wb.wdata : rf_rdata2_i;

    // execute only holds a bubble after a stall, so it never lasts two cycles
    a_stall_once: assert property (@(posedge clk) disable iff (reset_i)
        stall_o |-> ds_valid ##1 !stall_o);

endmodule

// File: hw/decode_stage.sv
module decode_stage (
    input  logic                      clk,
    input  logic                      reset_i,
    input  logic                      fetch_valid_i,
    input  logic [core_pkg::XLEN-1:0] fetch_pc_i,
    input  logic [31:0]               fetch_inst_i,
    output logic                      fetch_ready_o,
    input  logic                      stall_i,
    input  logic                      redirect_now_i,
    input  logic                      redirect_valid_i,
    uop_if.src                        uop
);
    import core_pkg::*;

    logic            id_valid;
    logic [XLEN-1:0] id_pc;
    inst_u           id_inst;

    assign fetch_ready_o = !(id_valid && stall_i);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            id_valid <= 1'b0;
        end else if (redirect_now_i || redirect_valid_i) begin
            id_valid <= 1'b0;
        end else if (fetch_ready_o) begin
            id_valid <= fetch_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (redirect_now_i || redirect_valid_i) begin
            id_inst <= INST_NOP;
        end else if (fetch_ready_o && fetch_valid_i) begin
            id_pc   <= fetch_pc_i;
            id_inst <= fetch_inst_i;
        end
    end

    assign uop.valid    = id_valid;
    assign uop.pc       = id_pc;
    assign uop.rs1_data = '0;
    assign uop.rs2_data = '0;

    ////////////////////////////////////////////////////////////////////////////
    // decode, anything outside the subset stays a no-op
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        uop.alu_op  = ALU_ADD;
        uop.br_kind = BR_NONE;
        uop.use_imm = 1'b0;
        uop.imm     = '0;
        uop.rd      = '0;
        uop.rf_wen  = 1'b0;
        uop.link    = 1'b0;
        uop.rs1     = '0;
        uop.rs2     = '0;
        case (id_inst.r.opcode)
            OPC_OP: begin
                if (id_inst.r.funct7 == 7'h00 ||
                    (id_inst.r.funct7 == 7'h20 && id_inst.r.funct3 == F3_ADD_SUB)) begin
                    uop.rs1    = id_inst.r.rs1;
                    uop.rs2    = id_inst.r.rs2;
                    uop.rd     = id_inst.r.rd;
                    uop.rf_wen = 1'b1;
                    case (id_inst.r.funct3)
                        F3_ADD_SUB: uop.alu_op = id_inst.r.funct7[5] ? ALU_SUB : ALU_ADD;
                        F3_AND:     uop.alu_op = ALU_AND;
                        F3_OR:      uop.alu_op = ALU_OR;
                        F3_XOR:     uop.alu_op = ALU_XOR;
                        default:    uop.rf_wen = 1'b0;
                    endcase
                end
            end
            OPC_OP_IMM: begin
                // addi only
                if (id_inst.i.funct3 == F3_ADD_SUB) begin
                    uop.rs1     = id_inst.i.rs1;
                    uop.rd      = id_inst.i.rd;
                    uop.rf_wen  = 1'b1;
                    uop.use_imm = 1'b1;
                    uop.imm     = {{20{id_inst.i.imm_11_0[11]}}, id_inst.i.imm_11_0};
                end
            end
            OPC_LUI: begin
                uop.rd      = id_inst.u.rd;
                uop.rf_wen  = 1'b1;
                uop.use_imm = 1'b1;
                uop.alu_op  = ALU_PASS2;
                uop.imm     = {id_inst.u.imm_31_12, 12'b0};
            end
            OPC_BRANCH: begin
                if (id_inst.b.funct3 == F3_BEQ || id_inst.b.funct3 == F3_BNE) begin
                    uop.br_kind = (id_inst.b.funct3 == F3_BNE) ? BR_NE : BR_EQ;
                    uop.rs1     = id_inst.b.rs1;
                    uop.rs2     = id_inst.b.rs2;
                    uop.imm     = {{19{id_inst.b.imm_12}}, id_inst.b.imm_12, id_inst.b.imm_11,
                                   id_inst.b.imm_10_5, id_inst.b.imm_4_1, 1'b0};
                end
            end
            OPC_JAL: begin
                uop.br_kind = BR_JAL;
                uop.rd      = id_inst.j.rd;
                uop.rf_wen  = 1'b1;
                uop.link    = 1'b1;
                uop.imm     = {{11{id_inst.j.imm_20}}, id_inst.j.imm_20, id_inst.j.imm_19_12,
                               id_inst.j.imm_11, id_inst.j.imm_10_1, 1'b0};
            end
            default: ;
        endcase
    end

    // a held entry keeps fetch waiting and moves on next cycle
    a_hold: assert property (@(posedge clk) disable iff (reset_i)
        (id_valid && stall_i && !redirect_now_i && !redirect_valid_i)
            |-> !fetch_ready_o ##1 (id_valid && !stall_i));

endmodule

// File: hw/core_ifs.sv
interface uop_if;
    import core_pkg::*;

    logic                  valid;
    logic [XLEN-1:0]       pc;
    alu_op_e               alu_op;
    br_kind_e              br_kind;
    logic                  use_imm;
    logic [XLEN-1:0]       imm;
    logic [REG_ADDR_W-1:0] rd;
    logic                  rf_wen;
    logic                  link;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    // resolved operands, filled in by data select
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;

    modport src (
        output valid, pc, alu_op, br_kind, use_imm, imm, rd, rf_wen, link,
               rs1, rs2, rs1_data, rs2_data
    );
    modport dst (
        input  valid, pc, alu_op, br_kind, use_imm, imm, rd, rf_wen, link,
               rs1, rs2, rs1_data, rs2_data
    );
endinterface

interface fwd_if;
    import core_pkg::*;

    logic                  valid;
    // wdata is final and may be picked up now
    logic                  fwdable;
    logic [REG_ADDR_W-1:0] addr;
    logic [XLEN-1:0]       wdata;

    modport drv (output valid, fwdable, addr, wdata);
    modport rcv (input  valid, fwdable, addr, wdata);
endinterface

// File: hw/core_pkg.sv
package core_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    // major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    // funct3 values of the supported subset
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;

    // addi x0, x0, 0
    localparam logic [31:0] INST_NOP = 32'h0000_0013;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_PASS2
    } alu_op_e;

    typedef enum logic [1:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_JAL
    } br_kind_e;

    ////////////////////////////////////////////////////////////////////////////
    // one instruction word, five field layouts
    ////////////////////////////////////////////////////////////////////////////
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm_11_0;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic       imm_12;
            logic [5:0] imm_10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm_4_1;
            logic       imm_11;
            logic [6:0] opcode;
        } b;
        struct packed {
            logic       imm_20;
            logic [9:0] imm_10_1;
            logic       imm_11;
            logic [7:0] imm_19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j;
        struct packed {
            logic [19:0] imm_31_12;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u;
    } inst_u;

endpackage
